// File: compile.f
hdl/memPkg.sv
hdl/portPkg.sv
hdl/accessDecoder.sv
hdl/ramBank.sv
hdl/readCollector.sv
hdl/hackMemory.sv
test/hackMemory_props.sv
test/hackMemoryTb.sv

// File: run.sh
#!/bin/sh
# Build and run the hackMemory testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log
FAIL_MSG="Test failed"
PASS_MSG="Test passed"

verilator --binary --assert --timescale 1ns/1ps \
    --top-module hackMemoryTb \
    -Mdir "$BUILD_DIR" \
    -f compile.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/VhackMemoryTb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "$FAIL_MSG" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi

if ! grep -q "$PASS_MSG" "$LOG"; then
    echo "Simulation ended without a verdict"
    exit 1
fi

echo "Simulation finished cleanly"
exit 0

// File: test/hackMemoryTb.sv
`timescale 1ns/1ps

module hackMemoryTb
    import memPkg::*, portPkg::*;
();

    localparam int   AckTimeout = 20;       // Cycles allowed per ack edge
    localparam int   RandomOps  = 200;
    localparam logic OpWrite    = 1'b1;
    localparam logic OpRead     = 1'b0;

    logic    clk;
    logic    rst;
    logic    req;
    logic    we;
    memAddr  addr;
    dataWord wdata;
    logic    ack;
    dataWord rdata;

    dataWord refMem  [1 << AddrWidth];      // Reference memory model
    logic    written [1 << AddrWidth];
    dataWord lastRead;

    logic    tblWrite  [$];
    memAddr  tblAddr   [$];
    dataWord tblData   [$];
    dataWord tblExpect [$];
    int      tblHold   [$];                 // Extra cycles req stays high

    int      checks;
    int      mismatches;
    int      timeouts;
    int      skipped;
    integer  seed;

    hackMemory uut (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .we    (we),
        .addr  (addr),
        .wdata (wdata),
        .ack   (ack),
        .rdata (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
        end
    endtask

    task automatic addRow(input logic isWrite, input memAddr a, input dataWord d,
                          input dataWord expected, input int hold);
        tblWrite.push_back(isWrite);
        tblAddr.push_back(a);
        tblData.push_back(d);
        tblExpect.push_back(expected);
        tblHold.push_back(hold);
    endtask

    task automatic buildTable();
        memAddr  base;
        memAddr  top;
        dataWord lo;
        dataWord hi;
        addRow(OpWrite, 12'h000, 16'h1234, '0, 0);
        addRow(OpRead,  12'h000, '0, 16'h1234, 0);
        addRow(OpWrite, 12'hFFF, 16'hBEEF, '0, 0);
        addRow(OpRead,  12'hFFF, '0, 16'hBEEF, 0);
        // First and last word of each bank
        for (int b = 0; b < BankCount; b++) begin
            base = memAddr'(b * BankDepth);
            top  = base + memAddr'(BankDepth - 1);
            lo   = 16'hA000 + dataWord'(b << 8);
            hi   = 16'h50FF + dataWord'(b << 8);
            addRow(OpWrite, base, lo, '0, 0);
            addRow(OpRead,  base, '0, lo, 0);
            addRow(OpWrite, top, hi, '0, 0);
            addRow(OpRead,  top, '0, hi, 0);
        end
        for (int b = 0; b < BankCount; b++) begin
            addRow(OpWrite, {bankIndex'(b), 9'h0A5}, 16'hC000 + dataWord'(b * 16'h0111), '0, 0);
        end
        // All writes land before any read, so a shared store would show here
        for (int b = 0; b < BankCount; b++) begin
            addRow(OpRead, {bankIndex'(b), 9'h0A5}, '0, 16'hC000 + dataWord'(b * 16'h0111), 0);
        end
        addRow(OpWrite, 12'h2A7, 16'h7E57, '0, 4);     // Requester stalls after ack
        addRow(OpRead,  12'h2A7, '0, 16'h7E57, 3);
        addRow(OpRead,  12'h0A5, '0, 16'hC000, 0);
    endtask

    // Four-phase transaction, returns rdata as seen with ack high
    task automatic runAccess(input logic isWrite, input memAddr a, input dataWord d,
                             input int hold, output dataWord got);
        int waitCount;
        got = '0;
        @(negedge clk);
        we    = isWrite;
        addr  = a;
        wdata = d;
        req   = 1'b1;
        waitCount = 0;
        while (!ack && waitCount < AckTimeout) begin
            @(negedge clk);
            waitCount++;
        end
        if (!ack) begin
            timeouts++;
            $display("Timeout: ack never rose for the access at address 0x%h", a);
        end else begin
            checkValue("ack latency", waitCount, AccessLatency);
        end
        got = rdata;
        repeat (hold) begin
            @(negedge clk);
            checkValue("ack", 32'(ack), 32'(1'b1));
        end
        req = 1'b0;
        waitCount = 0;
        while (ack && waitCount < AckTimeout) begin
            @(negedge clk);
            waitCount++;
        end
        if (ack) begin
            timeouts++;
            $display("Timeout: ack stayed high after req dropped at address 0x%h", a);
        end else begin
            checkValue("ack release", waitCount, 1);
        end
    endtask

    task automatic applyAccess(input logic isWrite, input memAddr a, input dataWord d,
                               input dataWord expected, input int hold);
        dataWord got;
        runAccess(isWrite, a, d, hold, got);
        if (isWrite) begin
            checkValue("rdata", 32'(got), 32'(lastRead));  // Writes keep the last read word
            refMem[a]  = d;
            written[a] = 1'b1;
        end else begin
            checkValue("rdata", 32'(got), 32'(expected));
            lastRead = expected;
        end
    endtask

    initial begin
        logic [31:0] rnd;
        logic        isWrite;
        memAddr      a;
        dataWord     d;
        int          hold;
        seed       = 87424;
        checks     = 0;
        mismatches = 0;
        timeouts   = 0;
        skipped    = 0;
        lastRead   = '0;
        rst   = 1'b1;
        req   = 1'b0;
        we    = 1'b0;
        addr  = '0;
        wdata = '0;
        for (int i = 0; i < (1 << AddrWidth); i++) begin
            refMem[i]  = '0;
            written[i] = 1'b0;
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;
        checkValue("ack", 32'(ack), 32'(1'b0));
        checkValue("rdata", 32'(rdata), 32'(16'h0000));

        buildTable();
        for (int i = 0; i < tblWrite.size(); i++) begin
            applyAccess(tblWrite[i], tblAddr[i], tblData[i], tblExpect[i], tblHold[i]);
        end

        for (int i = 0; i < RandomOps; i++) begin
            rnd     = $random(seed);
            isWrite = rnd[0];
            a       = {rnd[10:8], 6'b000000, rnd[2:0]};   // Small window, reads hit earlier writes
            hold    = int'(rnd[17:16]);
            rnd     = $random(seed);
            d       = rnd[15:0];
            if (!isWrite && !written[a]) begin
                skipped++;
            end else begin
                applyAccess(isWrite, a, d, refMem[a], hold);
            end
        end

        $display("Checks %0d, mismatches %0d, timeouts %0d, skipped reads %0d",
                 checks, mismatches, timeouts, skipped);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: test/hackMemory_props.sv
`timescale 1ns/1ps

module hackMemoryProps
    import memPkg::*;
(
    input logic    clk,
    input logic    rst,
    input logic    req,
    input logic    ack,
    input bankMask load,
    input bankMask read
);

    // ack only rises at an edge that saw req high
    ackRiseNeedsReq: assert property (
        @(posedge clk) disable iff (rst) $rose(ack) |-> $past(req)
    ) else $error("ack rose while req was low");

    ackFallNeedsNoReq: assert property (
        @(posedge clk) disable iff (rst) $fell(ack) |-> !$past(req)
    ) else $error("ack fell while req was still high");

    // At most one bank strobed, never load and read together
    oneStrobe: assert property (
        @(posedge clk) disable iff (rst) $onehot0({load, read})
    ) else $error("more than one bank strobe set");

endmodule

bind hackMemory hackMemoryProps props (
    .clk  (clk),
    .rst  (rst),
    .req  (req),
    .ack  (ack),
    .load (load),
    .read (read)
);

// File: hdl/hackMemory.sv
`timescale 1ns/1ps

module hackMemory
    import memPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    req,
    input  logic    we,
    input  memAddr  addr,
    input  dataWord wdata,
    output logic    ack,
    output dataWord rdata
);

    bankMask   load;
    bankMask   read;
    bankOffset offset;
    dataWord   bankWdata;

    logic [BankCount*WordWidth-1:0] rdWords;   // Bank words side by side
    bankMask                        rdValids;

    accessDecoder decoder (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .we        (we),
        .addr      (addr),
        .wdata     (wdata),
        .ack       (ack),
        .load      (load),
        .read      (read),
        .offset    (offset),
        .bankWdata (bankWdata)
    );

    // Eight 512-word banks sharing offset and write data
    genvar b;
    generate
        for (b = 0; b < BankCount; b++) begin : banks
            ramBank bank (
                .clk     (clk),
                .rst     (rst),
                .load    (load[b]),
                .read    (read[b]),
                .offset  (offset),
                .wdata   (bankWdata),
                .rdWord  (rdWords[b*WordWidth +: WordWidth]),
                .rdValid (rdValids[b])
            );
        end
    endgenerate

    readCollector collector (
        .clk      (clk),
        .rst      (rst),
        .rdWords  (rdWords),
        .rdValids (rdValids),
        .rdata    (rdata)
    );

endmodule

// File: hdl/readCollector.sv
`timescale 1ns/1ps

module readCollector
    import memPkg::*;
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic [BankCount*WordWidth-1:0] rdWords,
    input  bankMask                        rdValids,
    output dataWord                        rdata
);

    dataWord selWord;
    logic    anyValid;

    // Pick the word of the bank that answered
    always_comb begin
        selWord  = '0;
        anyValid = 1'b0;
        for (int b = 0; b < BankCount; b++) begin
            if (rdValids[b]) begin
                selWord  = rdWords[b*WordWidth +: WordWidth];
                anyValid = 1'b1;
            end
        end
    end

    // Hold the last read word at the port
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else if (anyValid) begin
            rdata <= selWord;
        end
    end

endmodule

// File: hdl/ramBank.sv
`timescale 1ns/1ps

module ramBank
    import memPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      load,
    input  logic      read,
    input  bankOffset offset,
    input  dataWord   wdata,
    output dataWord   rdWord,
    output logic      rdValid
);

    dataWord mem [BankDepth];   // Contents survive reset

    // Synchronous write
    always_ff @(posedge clk) begin
        if (load) begin
            mem[offset] <= wdata;
        end
    end

    // Registered read word
    always_ff @(posedge clk) begin
        if (read) begin
            rdWord <= mem[offset];
        end
    end

    // One-cycle pulse after a read strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            rdValid <= 1'b0;
        end else begin
            rdValid <= read;
        end
    end

endmodule

// File: hdl/accessDecoder.sv
`timescale 1ns/1ps

module accessDecoder
    import memPkg::*, portPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req,
    input  logic      we,
    input  memAddr    addr,
    input  dataWord   wdata,
    output logic      ack,
    output bankMask   load,
    output bankMask   read,
    output bankOffset offset,
    output dataWord   bankWdata
);

    portState  state;

    bankIndex  reqBank;
    bankOffset reqOffset;
    bankMask   bankSel;

    // Split the port address into bank and word
    assign reqBank   = addr[AddrWidth-1 -: BankBits];
    assign reqOffset = addr[OffsetBits-1:0];
    assign bankSel   = bankMask'(1) << reqBank;

    // Port state machine
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
            ack   <= 1'b0;
            load  <= '0;
            read  <= '0;
        end else begin
            case (state)
                Idle: begin
                    if (req) begin
                        if (we) begin
                            load <= bankSel;
                        end else begin
                            read <= bankSel;
                        end
                        state <= Strobe;
                    end
                end

                Strobe: begin
                    load  <= '0;        // Strobes last one cycle
                    read  <= '0;
                    state <= Settle;
                end

                Settle: begin
                    ack   <= 1'b1;
                    state <= Ack;
                end

                Ack: begin
                    // Hold ack while the requester keeps req high
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= Idle;
                    end
                end

                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

    // Payload taken with the request, no reset needed
    always_ff @(posedge clk) begin
        if (state == Idle && req) begin
            offset    <= reqOffset;
            bankWdata <= wdata;
        end
    end

endmodule

// File: hdl/portPkg.sv
package portPkg;

    // Four-phase port sequencing
    typedef enum logic [1:0] {
        Idle,       // Waiting for req
        Strobe,     // Bank strobe on the wires
        Settle,     // Collector captures read word
        Ack         // ack high until req drops
    } portState;

    // Edges from the first req sample to ack high
    localparam int AccessLatency = 3;

endpackage

// File: hdl/memPkg.sv
package memPkg;

    // 4K x 16 data memory built from eight equal banks
    localparam int WordWidth  = 16;
    localparam int AddrWidth  = 12;
    localparam int BankCount  = 8;
    localparam int BankBits   = 3;                  // Upper address bits
    localparam int OffsetBits = 9;                  // Lower address bits
    localparam int BankDepth  = 1 << OffsetBits;    // 512 words

    // One memory word
    typedef logic [WordWidth-1:0] dataWord;

    // Full word address as seen at the port
    typedef logic [AddrWidth-1:0] memAddr;

    // Bank number and the word inside it
    typedef logic [BankBits-1:0] bankIndex;
    typedef logic [OffsetBits-1:0] bankOffset;

    // One bit per bank for strobes and valid flags
    typedef logic [BankCount-1:0] bankMask;

endpackage
